// File: sources.f
logic/flagram_pkg.sv
logic/flagram_dispatch.sv
logic/flagram_bank.sv
logic/flagram_collect.sv
logic/flagram_top.sv
test/flagram_checker.sv
test/flagram_tb.sv

// File: test/flagram_tb.sv
module flagram_tb;

    import flagram_pkg::*;

    localparam int NUM_BANKS  = 4;
    localparam int ADDR_W     = $clog2(NUM_BANKS) + WORD_ADDR_W;
    localparam int CLK_PERIOD = 100;
    localparam int BURST_LEN  = 12;
    localparam int RAND_CMDS  = 200;
    // reset check, write and read back, flag rules, independence, burst, random
    localparam int TOTAL_CMDS = NUM_BANKS + 2 * NUM_BANKS * WORDS + 3 * WORDS + 5
                                + BURST_LEN + RAND_CMDS;

    logic              i_w_clk;
    logic              i_reset;
    logic [ADDR_W-1:0] i_w_address;
    logic [WORD_W-1:0] i_w_data;
    logic              i_w_we;
    logic              i_w_oe;
    logic              i_w_flags_out;
    wire  [OUT_W-1:0]  o_w_out;

    // reference model state
    logic [WORD_W-1:0] ref_mem [NUM_BANKS][WORDS];
    logic [OUT_W-1:0]  ref_flags [NUM_BANKS];
    logic [OUT_W-1:0]  ref_out;
    logic [31:0]       lcg_state;

    // burst stimulus, strobes packed as {we, oe, flags}
    logic [2:0]        burst_strb [BURST_LEN];
    logic [ADDR_W-1:0] burst_addr [BURST_LEN];
    logic [WORD_W-1:0] burst_data [BURST_LEN];
    logic [OUT_W-1:0]  exp_q [$];

    flagram_top #(
        .NUM_BANKS(NUM_BANKS)
    ) dut_i (
        .i_w_clk       (i_w_clk),
        .i_reset       (i_reset),
        .i_w_address   (i_w_address),
        .i_w_data      (i_w_data),
        .i_w_we        (i_w_we),
        .i_w_oe        (i_w_oe),
        .i_w_flags_out (i_w_flags_out),
        .o_w_out       (o_w_out)
    );

    initial i_w_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_w_clk = ~i_w_clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [OUT_W-1:0] expected_flags(input logic [WORD_W-1:0] v);
        logic [OUT_W-1:0] f;
        int               ones;
        f    = '0;
        ones = 0;
        for (int i = 0; i < WORD_W; i++) begin
            ones += v[i];
        end
        f[FLAG_Z]    = (v == 0);
        f[FLAG_S]    = v[WORD_W-1];
        f[FLAG_E]    = (ones % 2 == 0);
        f[FLAG_O]    = (ones % 2 == 1);
        f[FLAG_C2]   = (v[2] == 1'b0);
        f[FLAG_S2]   = (v[2] == 1'b1);
        f[FLAG_G4]   = (v > 4);
        f[FLAG_L4]   = (v < 4);
        // zero or a single set bit
        f[FLAG_POW]  = (ones <= 1);
        f[FLAG_SMAX] = (v == 7);
        f[FLAG_SMIN] = (v == 8);
        f[FLAG_MAX]  = (v == 15);
        f[FLAG_PAL]  = (v == {v[0], v[1], v[2], v[3]});
        for (int i = 0; i < WORD_W - 1; i++) begin
            if (v[i] == v[i+1]) begin
                f[FLAG_SB2] = 1'b1;
            end
        end
        return f;
    endfunction

    // applies one command to the model and returns the expected output
    function automatic logic [OUT_W-1:0] model_cmd(input logic [2:0] strb,
            input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        int bank;
        int word;
        bank = addr[ADDR_W-1:WORD_ADDR_W];
        word = addr[WORD_ADDR_W-1:0];
        if (strb[2]) begin
            ref_mem[bank][word] = data;
            ref_out             = '0;
        end else if (strb[1]) begin
            ref_out                = '0;
            ref_out[WORD_W-1:0]    = ref_mem[bank][word];
            ref_flags[bank]        = expected_flags(ref_mem[bank][word]);
        end else if (strb[0]) begin
            ref_out = ref_flags[bank];
        end
        return ref_out;
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(input int bank, input int word);
        logic [ADDR_W-1:0] a;
        a = bank * WORDS + word;
        return a;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cmd(input logic [2:0] strb, input logic [ADDR_W-1:0] addr,
            input logic [WORD_W-1:0] data);
        i_w_we        <= strb[2];
        i_w_oe        <= strb[1];
        i_w_flags_out <= strb[0];
        i_w_address   <= addr;
        i_w_data      <= data;
    endtask

    task automatic check_out(input logic [OUT_W-1:0] exp);
        assert (o_w_out === exp) else begin
            $display("ERR t=%0t o_w_out expected %h actual %h", $time, exp, o_w_out);
            $display("*** TEST FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // one command, then three edges of latency
    task automatic do_cmd(input logic [2:0] strb, input logic [ADDR_W-1:0] addr,
            input logic [WORD_W-1:0] data);
        logic [OUT_W-1:0] exp;
        exp = model_cmd(strb, addr, data);
        @(posedge i_w_clk);
        drive_cmd(strb, addr, data);
        @(posedge i_w_clk);
        drive_cmd(3'b000, addr, data);
        repeat (2) @(posedge i_w_clk);
        @(negedge i_w_clk);
        check_out(exp);
    endtask

    task automatic set_burst(input int i, input logic [2:0] strb,
            input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        burst_strb[i] = strb;
        burst_addr[i] = addr;
        burst_data[i] = data;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        @(negedge i_w_clk);
        check_out('0);
        for (int b = 0; b < NUM_BANKS; b++) begin
            do_cmd(3'b001, addr_of(b, 0), '0);
        end
    endtask

    task automatic test_write_read();
        logic [WORD_W-1:0] d;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                d = w ^ (b * 5);
                do_cmd(3'b100, addr_of(b, w), d);
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                do_cmd(3'b010, addr_of(b, w), '0);
            end
        end
    endtask

    task automatic test_flag_rules();
        for (int v = 0; v < WORDS; v++) begin
            do_cmd(3'b100, addr_of(1, v), v);
            do_cmd(3'b010, addr_of(1, v), '0);
            do_cmd(3'b001, addr_of(1, 0), '0);
        end
    endtask

    // bank 2 is not read here and keeps its flags
    task automatic test_bank_independence();
        do_cmd(3'b010, addr_of(0, 2), '0);
        do_cmd(3'b010, addr_of(3, 9), '0);
        do_cmd(3'b001, addr_of(0, 0), '0);
        do_cmd(3'b001, addr_of(3, 0), '0);
        do_cmd(3'b001, addr_of(2, 0), '0);
    endtask

    task automatic test_priority_pipeline();
        set_burst(0, 3'b111, addr_of(2, 5), 4'hA);
        set_burst(1, 3'b011, addr_of(2, 5), 4'h3);
        set_burst(2, 3'b001, addr_of(2, 0), 4'h0);
        set_burst(3, 3'b101, addr_of(1, 3), 4'h7);
        set_burst(4, 3'b010, addr_of(1, 3), 4'h0);
        set_burst(5, 3'b011, addr_of(1, 3), 4'h0);
        set_burst(6, 3'b001, addr_of(1, 0), 4'h0);
        set_burst(7, 3'b000, addr_of(0, 0), 4'h0);
        set_burst(8, 3'b110, addr_of(0, 0), 4'h8);
        set_burst(9, 3'b010, addr_of(0, 0), 4'h0);
        set_burst(10, 3'b001, addr_of(0, 0), 4'h0);
        set_burst(11, 3'b010, addr_of(3, 15), 4'h0);
        // one command per cycle, each result three edges later
        for (int cyc = 0; cyc < BURST_LEN + 3; cyc++) begin
            @(posedge i_w_clk);
            if (cyc < BURST_LEN) begin
                exp_q.push_back(model_cmd(burst_strb[cyc], burst_addr[cyc], burst_data[cyc]));
                drive_cmd(burst_strb[cyc], burst_addr[cyc], burst_data[cyc]);
            end else begin
                drive_cmd(3'b000, '0, '0);
            end
            @(negedge i_w_clk);
            if (cyc >= 3) begin
                check_out(exp_q.pop_front());
            end
        end
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        for (int n = 0; n < RAND_CMDS; n++) begin
            r = next_rand();
            do_cmd(r[30:28], r[ADDR_W+15:16], r[11:8]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        i_reset       = 1'b1;
        i_w_address   = '0;
        i_w_data      = '0;
        i_w_we        = 1'b0;
        i_w_oe        = 1'b0;
        i_w_flags_out = 1'b0;
        lcg_state     = 32'h371dd84e;
        ref_out       = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            ref_flags[b] = '0;
        end
        repeat (4) @(posedge i_w_clk);
        i_reset <= 1'b0;
        test_reset_state();
        test_write_read();
        test_flag_rules();
        test_bank_independence();
        test_priority_pipeline();
        test_random_mix();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(TOTAL_CMDS * 10 * CLK_PERIOD);
        $display("timeout: the commands did not complete in the expected time");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: test/flagram_checker.sv
module flagram_checker (
    input  wire                           i_w_clk,
    input  wire                           i_reset,
    input  wire                           i_w_we,
    input  wire                           i_w_oe,
    input  wire                           i_w_flags_out,
    input  wire [flagram_pkg::OUT_W-1:0]  i_w_out
);

    import flagram_pkg::*;

    logic l_w_idle;

    assign l_w_idle = !(i_w_we || i_w_oe || i_w_flags_out);

    ////////////////////////////////////////////////////////////////////////////
    // output properties
    ////////////////////////////////////////////////////////////////////////////

    // bits above the flag word never reach the output
    a_top_bits_zero: assert property (@(posedge i_w_clk) disable iff (i_reset)
        i_w_out[OUT_W-1:FLAG_W] == '0)
        else $error("o_w_out bits above the flag word are set");

    // a write lands three edges after its strobe is sampled
    a_write_clears: assert property (@(posedge i_w_clk) disable iff (i_reset)
        i_w_we |-> ##3 (i_w_out == '0))
        else $error("o_w_out not cleared three edges after a write");

    a_idle_stable: assert property (@(posedge i_w_clk) disable iff (i_reset)
        l_w_idle [*3] |=> $stable(i_w_out))
        else $error("o_w_out changed with no command in flight");

    a_reset_zero: assert property (@(posedge i_w_clk)
        $fell(i_reset) |-> (i_w_out == '0))
        else $error("o_w_out not zero after reset");

endmodule

bind flagram_top flagram_checker checker_i (
    .i_w_clk       (i_w_clk),
    .i_reset       (i_reset),
    .i_w_we        (i_w_we),
    .i_w_oe        (i_w_oe),
    .i_w_flags_out (i_w_flags_out),
    .i_w_out       (o_w_out)
);

// File: logic/flagram_top.sv
module flagram_top #(
    parameter int NUM_BANKS = 4
) (
    input  wire                                                    i_w_clk,
    input  wire                                                    i_reset,
    input  wire [$clog2(NUM_BANKS)+flagram_pkg::WORD_ADDR_W-1:0]   i_w_address,
    input  wire [flagram_pkg::WORD_W-1:0]                          i_w_data,
    input  wire                                                    i_w_we,
    input  wire                                                    i_w_oe,
    input  wire                                                    i_w_flags_out,
    output wire [flagram_pkg::OUT_W-1:0]                           o_w_out
);

    import flagram_pkg::*;

    // registered command, shared by all banks
    wire [NUM_BANKS-1:0]       l_w_bank_sel;
    flagram_op_e               l_w_op;
    wire [WORD_ADDR_W-1:0]     l_w_word_addr;
    wire [WORD_W-1:0]          l_w_wdata;

    // bank results, flattened for the collector
    wire [NUM_BANKS*OUT_W-1:0] l_w_results;
    wire [NUM_BANKS-1:0]       l_w_done;

    flagram_dispatch #(
        .NUM_BANKS(NUM_BANKS)
    ) dispatch_i (
        .i_w_clk       (i_w_clk),
        .i_reset       (i_reset),
        .i_w_address   (i_w_address),
        .i_w_data      (i_w_data),
        .i_w_we        (i_w_we),
        .i_w_oe        (i_w_oe),
        .i_w_flags_out (i_w_flags_out),
        .o_w_bank_sel  (l_w_bank_sel),
        .o_w_op        (l_w_op),
        .o_w_word_addr (l_w_word_addr),
        .o_w_wdata     (l_w_wdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // banks
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        flagram_bank bank_i (
            .i_w_clk       (i_w_clk),
            .i_reset       (i_reset),
            .i_w_sel       (l_w_bank_sel[b]),
            .i_w_op        (l_w_op),
            .i_w_word_addr (l_w_word_addr),
            .i_w_wdata     (l_w_wdata),
            .o_w_result    (l_w_results[b*OUT_W +: OUT_W]),
            .o_w_done      (l_w_done[b])
        );
    end

    flagram_collect #(
        .NUM_BANKS(NUM_BANKS)
    ) collect_i (
        .i_w_clk     (i_w_clk),
        .i_reset     (i_reset),
        .i_w_done    (l_w_done),
        .i_w_results (l_w_results),
        .o_w_out     (o_w_out)
    );

endmodule

// File: logic/flagram_collect.sv
module flagram_collect #(
    parameter int NUM_BANKS = 4
) (
    input  wire                                        i_w_clk,
    input  wire                                        i_reset,
    input  wire [NUM_BANKS-1:0]                        i_w_done,
    input  wire [NUM_BANKS*flagram_pkg::OUT_W-1:0]     i_w_results,
    output logic [flagram_pkg::OUT_W-1:0]              o_w_out
);

    import flagram_pkg::*;

    logic [OUT_W-1:0] l_w_pick;
    logic             l_w_any;

    ////////////////////////////////////////////////////////////////////////////
    // result select
    ////////////////////////////////////////////////////////////////////////////

    // done is one-hot at most, so an and-or tree is enough
    always_comb begin
        l_w_pick = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (i_w_done[b]) begin
                l_w_pick = l_w_pick | i_w_results[b*OUT_W +: OUT_W];
            end
        end
    end

    assign l_w_any = |i_w_done;

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    // holds the last result while no bank reports
    always_ff @(posedge i_w_clk) begin
        if (i_reset) begin
            o_w_out <= '0;
        end else if (l_w_any) begin
            o_w_out <= l_w_pick;
        end
    end

endmodule

// File: logic/flagram_bank.sv
module flagram_bank (
    input  wire                                  i_w_clk,
    input  wire                                  i_reset,
    input  wire                                  i_w_sel,
    input  flagram_pkg::flagram_op_e             i_w_op,
    input  wire [flagram_pkg::WORD_ADDR_W-1:0]   i_w_word_addr,
    input  wire [flagram_pkg::WORD_W-1:0]        i_w_wdata,
    output logic [flagram_pkg::OUT_W-1:0]        o_w_result,
    output logic                                 o_w_done
);

    import flagram_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // flag classifier
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [FLAG_W-1:0] classify(input logic [WORD_W-1:0] v);
        logic [FLAG_W-1:0] f;
        f            = '0;
        f[FLAG_Z]    = ~(|v);
        f[FLAG_S]    = v[3];
        f[FLAG_E]    = ~(^v);
        f[FLAG_O]    = ^v;
        f[FLAG_C2]   = ~v[2];
        f[FLAG_S2]   = v[2];
        f[FLAG_G4]   = (v > 4'd4);
        f[FLAG_L4]   = (v < 4'd4);
        // zero counts as a power of two here
        f[FLAG_POW]  = (v == 4'd0) || (v == 4'd1) || (v == 4'd2) ||
                       (v == 4'd4) || (v == 4'd8);
        f[FLAG_SMAX] = (v == 4'd7);
        f[FLAG_SMIN] = (v == 4'd8);
        f[FLAG_MAX]  = (v == 4'd15);
        f[FLAG_PAL]  = (v[0] == v[3]) && (v[1] == v[2]);
        f[FLAG_SB2]  = (v[3] == v[2]) || (v[2] == v[1]) || (v[1] == v[0]);
        return f;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    logic [WORD_W-1:0] l_r_mem [WORDS];
    logic [FLAG_W-1:0] l_r_flags;
    logic [WORD_W-1:0] l_w_rd_word;
    logic              l_w_act;

    assign l_w_rd_word = l_r_mem[i_w_word_addr];
    assign l_w_act     = i_w_sel && (i_w_op != OP_NOP);

    // RAM and result path
    always_ff @(posedge i_w_clk) begin
        if (i_w_sel) begin
            case (i_w_op)
                OP_WRITE: begin
                    l_r_mem[i_w_word_addr] <= i_w_wdata;
                    o_w_result             <= '0;
                end
                OP_READ: begin
                    o_w_result <= {{(OUT_W - WORD_W){1'b0}}, l_w_rd_word};
                end
                OP_FLAGS: begin
                    // flags from before any update this cycle
                    o_w_result <= {{(OUT_W - FLAG_W){1'b0}}, l_r_flags};
                end
                default: begin
                    o_w_result <= o_w_result;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // flag register and done pulse
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_w_clk) begin
        if (i_reset) begin
            l_r_flags <= '0;
        end else if (i_w_sel && (i_w_op == OP_READ)) begin
            l_r_flags <= classify(l_w_rd_word);
        end
    end

    // one pulse per executed command
    always_ff @(posedge i_w_clk) begin
        if (i_reset) begin
            o_w_done <= 1'b0;
        end else begin
            o_w_done <= l_w_act;
        end
    end

endmodule

// File: logic/flagram_dispatch.sv
module flagram_dispatch #(
    parameter int NUM_BANKS = 4
) (
    input  wire                                                    i_w_clk,
    input  wire                                                    i_reset,
    input  wire [$clog2(NUM_BANKS)+flagram_pkg::WORD_ADDR_W-1:0]   i_w_address,
    input  wire [flagram_pkg::WORD_W-1:0]                          i_w_data,
    input  wire                                                    i_w_we,
    input  wire                                                    i_w_oe,
    input  wire                                                    i_w_flags_out,
    output logic [NUM_BANKS-1:0]                                   o_w_bank_sel,
    output flagram_pkg::flagram_op_e                               o_w_op,
    output logic [flagram_pkg::WORD_ADDR_W-1:0]                    o_w_word_addr,
    output logic [flagram_pkg::WORD_W-1:0]                         o_w_wdata
);

    import flagram_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);

    // bank field sits above the word address
    logic [BANK_W-1:0]      l_w_bank;
    logic [WORD_ADDR_W-1:0] l_w_word;
    flagram_op_e            l_w_op;
    logic [NUM_BANKS-1:0]   l_w_bank_sel;

    assign l_w_bank = i_w_address[BANK_W+WORD_ADDR_W-1:WORD_ADDR_W];
    assign l_w_word = i_w_address[WORD_ADDR_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // strobe decode
    ////////////////////////////////////////////////////////////////////////////

    // write wins over read, read wins over flags
    always_comb begin
        if (i_w_we) begin
            l_w_op = OP_WRITE;
        end else if (i_w_oe) begin
            l_w_op = OP_READ;
        end else if (i_w_flags_out) begin
            l_w_op = OP_FLAGS;
        end else begin
            l_w_op = OP_NOP;
        end
    end

    // one-hot bank select, empty for a nop
    always_comb begin
        l_w_bank_sel = '0;
        if (l_w_op != OP_NOP) begin
            l_w_bank_sel[l_w_bank] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // command register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_w_clk) begin
        if (i_reset) begin
            o_w_bank_sel <= '0;
            o_w_op       <= OP_NOP;
        end else begin
            o_w_bank_sel <= l_w_bank_sel;
            o_w_op       <= l_w_op;
        end
    end

    // address and data only matter when a bank is selected
    always_ff @(posedge i_w_clk) begin
        o_w_word_addr <= l_w_word;
        o_w_wdata     <= i_w_data;
    end

endmodule

// File: logic/flagram_pkg.sv
package flagram_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // data word stored in each RAM location
    localparam int WORD_W = 4;

    // address bits within one bank
    localparam int WORD_ADDR_W = 4;

    // words per bank
    localparam int WORDS = 2 ** WORD_ADDR_W;

    // result bus, wide enough for the flag word
    localparam int OUT_W = 16;

    // number of value-class flags kept per bank
    localparam int FLAG_W = 14;

    ////////////////////////////////////////////////////////////////////////////
    // command opcodes
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_FLAGS = 2'd3
    } flagram_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // flag bit positions, bits 15:14 of the flag word stay zero
    ////////////////////////////////////////////////////////////////////////////

    localparam int FLAG_Z    = 0;
    localparam int FLAG_S    = 1;
    localparam int FLAG_E    = 2;
    localparam int FLAG_O    = 3;
    localparam int FLAG_C2   = 4;
    localparam int FLAG_S2   = 5;
    localparam int FLAG_G4   = 6;
    localparam int FLAG_L4   = 7;
    localparam int FLAG_POW  = 8;
    localparam int FLAG_SMAX = 9;
    localparam int FLAG_SMIN = 10;
    localparam int FLAG_MAX  = 11;
    localparam int FLAG_PAL  = 12;
    localparam int FLAG_SB2  = 13;

endpackage
